// File: vmpeg_dvc.f
vmpeg_pkg.sv
dvc_interfaces.sv
dvc_bus_port.sv
mpeg_header_parser.sv
frame_event_fifo.sv
dvc_system_timer.sv
dvc_registers.sv
vmpeg_dvc.sv
vmpeg_dvc_properties.sv
vmpeg_dvc_tb.sv

// File: Bender.yml
package:
  name: vmpeg_dvc

sources:
  - vmpeg_pkg.sv
  - dvc_interfaces.sv
  - dvc_bus_port.sv
  - mpeg_header_parser.sv
  - frame_event_fifo.sv
  - dvc_system_timer.sv
  - dvc_registers.sv
  - vmpeg_dvc.sv
  - target: test
    files:
      - vmpeg_dvc_properties.sv
      - vmpeg_dvc_tb.sv

// File: vmpeg_dvc_tb.sv
module vmpeg_dvc_tb;
    import vmpeg_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int DCLK_DIVIDER = 4;
    localparam int FIFO_DEPTH   = 8;
    localparam int RESET_CYCLES = 10;

    // Cycle budget of each test
    localparam int REG_TEST_CYCLES    = 60;
    localparam int TIMER_TEST_CYCLES  = 200;
    localparam int XFER_TEST_CYCLES   = 120;
    localparam int DMA_TEST_CYCLES    = 80;
    localparam int PACING_TEST_CYCLES = 120;
    localparam int TOTAL_CYCLES = RESET_CYCLES + REG_TEST_CYCLES + TIMER_TEST_CYCLES +
                                  XFER_TEST_CYCLES + DMA_TEST_CYCLES + PACING_TEST_CYCLES;
    localparam int WATCHDOG_TIME = 2 * TOTAL_CYCLES * CLK_PERIOD;

    localparam logic [15:0] IER_VALUE  = 16'h0107;
    localparam logic [15:0] TCNT_VALUE = 16'h1234;
    localparam logic [15:0] IVEC_VALUE = 16'h05A8;
    localparam int          TIM_TCNT   = 2;

    logic        clk;
    logic        reset;
    logic [23:1] address;
    logic [15:0] din;
    logic [15:0] dout;
    logic        uds;
    logic        lds;
    logic        write_strobe;
    logic        cs;
    logic        bus_ack;
    logic        intreq;
    logic        intack;
    logic        req;
    logic        ack;
    logic        rdy;
    logic        dtc;
    logic        done_in;
    logic        vsync;

    logic [7:0] byte_q[$];
    int         seed;

    vmpeg_dvc #(.DCLK_DIVIDER(DCLK_DIVIDER), .FIFO_DEPTH(FIFO_DEPTH)) uut (
        .clk, .reset, .address, .din, .dout, .uds, .lds, .write_strobe, .cs,
        .bus_ack, .intreq, .intack, .req, .ack, .rdy, .dtc, .done_in, .vsync
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[ERROR] t=%0t %s expected 0x%0h actual 0x%0h",
                     $time, name, expected, actual);
            abort_run();
        end
    endtask

    function automatic logic probe(input string name);
        case (name)
            "bus_ack": probe = bus_ack;
            "intreq":  probe = intreq;
            "req":     probe = req;
            default:   probe = 1'bx;
        endcase
    endfunction

    // Sampled on the falling edge, away from the DUT's updates
    task automatic wait_level(input string name, input logic level, input int max_cycles,
                              output int waited);
        waited = 0;
        @(negedge clk);
        while (probe(name) !== level) begin
            if (waited >= max_cycles) begin
                $display("Timeout: %s did not reach %b within %0d cycles",
                         name, level, max_cycles);
                abort_run();
            end
            waited++;
            @(negedge clk);
        end
    endtask

    // One CPU access; the strobe cycle is the one with bus_ack high
    task automatic bus_access(input logic [14:0] word_addr, input logic wr,
                              input logic [15:0] wdata, output logic [15:0] rdata);
        int waited;
        @(posedge clk);
        address      <= {8'h00, word_addr};
        din          <= wdata;
        write_strobe <= wr;
        cs           <= 1'b1;
        uds          <= 1'b1;
        lds          <= 1'b1;
        wait_level("bus_ack", 1'b1, 4, waited);
        rdata = dout;
        @(posedge clk);
        cs           <= 1'b0;
        uds          <= 1'b0;
        lds          <= 1'b0;
        write_strobe <= 1'b0;
    endtask

    task automatic write_reg(input logic [14:0] word_addr, input logic [15:0] wdata);
        logic [15:0] unused;
        bus_access(word_addr, 1'b1, wdata, unused);
    endtask

    task automatic read_reg(input logic [14:0] word_addr, output logic [15:0] rdata);
        bus_access(word_addr, 1'b0, 16'h0000, rdata);
    endtask

    task automatic add_start_code(input logic [7:0] code);
        byte_q.push_back(8'h00);
        byte_q.push_back(8'h00);
        byte_q.push_back(8'h01);
        byte_q.push_back(code);
    endtask

    task automatic add_gop(input logic [7:0] b1, input logic [7:0] b2, input logic [7:0] b3);
        add_start_code(SC_GOP);
        byte_q.push_back(8'h12);
        byte_q.push_back(b1);
        byte_q.push_back(b2);
        byte_q.push_back(b3);
    endtask

    task automatic add_picture(input logic [9:0] tsn);
        add_start_code(SC_PIC);
        byte_q.push_back(tsn[9:2]);
        byte_q.push_back({tsn[1:0], 6'h15});
        // Remaining header bytes carry nothing the card decodes
        byte_q.push_back(8'($random(seed)));
        byte_q.push_back(8'($random(seed)));
    endtask

    // Expected TIMECODE from GOP bytes 1 to 3
    function automatic logic [31:0] gop_timecode(input logic [7:0] b1, input logic [7:0] b2,
                                                 input logic [7:0] b3);
        logic [31:0] tc;
        tc        = '0;
        tc[27:25] = b1[2:0];
        tc[24:22] = b2[7:5];
        tc[21:17] = b2[4:0];
        tc[16]    = b3[7];
        return tc;
    endfunction

    task automatic send_xfer();
        logic [15:0] word;
        while (byte_q.size() >= 2) begin
            word[15:8] = byte_q.pop_front();
            word[7:0]  = byte_q.pop_front();
            write_reg(REG_XFER, word);
        end
    endtask

    // DMA beats with an idle cycle between them
    task automatic send_dma();
        logic [15:0] word;
        int          waited;
        wait_level("req", 1'b1, 4, waited);
        while (byte_q.size() >= 2) begin
            word[15:8] = byte_q.pop_front();
            word[7:0]  = byte_q.pop_front();
            @(posedge clk);
            din <= word;
            ack <= 1'b1;
            dtc <= 1'b1;
            @(posedge clk);
            ack <= 1'b0;
            dtc <= 1'b0;
        end
    endtask

    task automatic pulse_vsync();
        @(posedge clk);
        vsync <= 1'b1;
        repeat (3) @(posedge clk);
        vsync <= 1'b0;
        repeat (3) @(posedge clk);
    endtask

    task automatic check_release(input logic pic, input logic [15:0] tmpref);
        logic [15:0] rd;
        read_reg(REG_ISR, rd);
        check_value("ISR[2]", pic, rd[ISR_PIC]);
        read_reg(REG_TMPREF, rd);
        check_value("TMPREF", tmpref, rd);
    endtask

    task automatic test_registers();
        logic [15:0] rd;
        read_reg(REG_TCNT, rd);
        check_value("TCNT after reset", TCNT_RESET, rd);
        write_reg(REG_IER, IER_VALUE);
        write_reg(REG_TCNT, TCNT_VALUE);
        write_reg(REG_IVEC, IVEC_VALUE);
        read_reg(REG_IER, rd);
        check_value("IER", IER_VALUE, rd);
        read_reg(REG_TCNT, rd);
        check_value("TCNT", TCNT_VALUE, rd);
        read_reg(REG_IVEC, rd);
        check_value("IVEC", IVEC_VALUE, rd);
    endtask

    task automatic test_timer_interrupt();
        logic [15:0] rd;
        int          waited;
        int          elapsed;
        int          period;
        time         t_reload;
        // 8*TCNT+1 ticks, each DCLK_DIVIDER cycles
        period = (8 * TIM_TCNT + 1) * DCLK_DIVIDER;
        write_reg(REG_TCNT, 16'(TIM_TCNT));
        write_reg(REG_TRLD, 16'h0000);
        t_reload = $time;
        read_reg(REG_ISR, rd);
        write_reg(REG_IER, IER_VALUE);
        wait_level("intreq", 1'b1, period + 20, waited);
        elapsed = int'(($time - t_reload) / CLK_PERIOD);
        assert (elapsed >= period - 4 && elapsed <= period + 1) else begin
            $display("[ERROR] t=%0t timer interval expected %0d cycles actual %0d",
                     $time, period, elapsed);
            abort_run();
        end
        @(posedge clk);
        intack <= 1'b1;
        @(negedge clk);
        check_value("dout vector", {IVEC_VALUE[10:3], IVEC_VALUE[10:3]}, dout);
        @(posedge clk);
        intack <= 1'b0;
        read_reg(REG_ISR, rd);
        check_value("ISR[8]", 1'b1, rd[ISR_TIM]);
        @(negedge clk);
        check_value("intreq after ISR read", 1'b0, intreq);
        // A second read sees the flags gone
        read_reg(REG_ISR, rd);
        check_value("ISR after clearing read", 16'h0000, rd);
        // Park the timer so TIM stays quiet for the stream tests
        write_reg(REG_TCNT, 16'hFFFF);
        write_reg(REG_TRLD, 16'h0000);
        read_reg(REG_ISR, rd);
    endtask

    task automatic test_xfer_stream();
        logic [15:0] rd;
        logic [31:0] tc;
        tc = gop_timecode(8'h05, 8'hB6, 8'h80);
        add_start_code(SC_SEQ);
        byte_q.push_back(8'hAA);
        byte_q.push_back(8'hBB);
        add_gop(8'h05, 8'hB6, 8'h80);
        add_picture(10'd0);
        send_xfer();
        pulse_vsync();
        pulse_vsync();
        read_reg(REG_ISR, rd);
        check_value("ISR[2:0]", 3'b111, rd[2:0]);
        read_reg(REG_TIMECODE_HI, rd);
        check_value("TIMECODE_HI", tc[31:16], rd);
        read_reg(REG_TIMECODE_LO, rd);
        check_value("TIMECODE_LO", tc[15:0], rd);
        read_reg(REG_TMPREF, rd);
        check_value("TMPREF", 16'(0) << 2, rd);
    endtask

    task automatic test_dma_stream();
        logic [15:0] rd;
        int          waited;
        write_reg(REG_SYSCMD, SYSCMD_DMA_START);
        @(negedge clk);
        check_value("req", 1'b1, req);
        check_value("rdy", 1'b1, rdy);
        add_picture(10'd1);
        send_dma();
        @(posedge clk);
        done_in <= 1'b1;
        ack     <= 1'b1;
        @(posedge clk);
        done_in <= 1'b0;
        ack     <= 1'b0;
        wait_level("req", 1'b0, 4, waited);
        check_value("rdy", 1'b0, rdy);
        pulse_vsync();
        pulse_vsync();
        read_reg(REG_ISR, rd);
        check_value("ISR[2]", 1'b1, rd[ISR_PIC]);
        read_reg(REG_TMPREF, rd);
        check_value("TMPREF[11:2]", 10'd1, rd[11:2]);
    endtask

    task automatic test_release_pacing();
        logic [15:0] rd;
        // Picture 2 is next in order, picture 7 is not
        add_picture(10'd2);
        add_picture(10'd7);
        send_xfer();
        read_reg(REG_ISR, rd);
        pulse_vsync();
        check_release(1'b0, 16'h0004);
        pulse_vsync();
        check_release(1'b1, 16'(2) << 2);
        pulse_vsync();
        check_release(1'b0, 16'(2) << 2);
        pulse_vsync();
        check_release(1'b1, 16'(2) << 2);
    endtask

    initial begin
        #(WATCHDOG_TIME);
        $display("Watchdog expired before the tests finished");
        abort_run();
    end

    // Bound assertion failures end the run at once
    always @(negedge clk) begin
        if (uut.u_props.fail_count != 0) begin
            $display("Bound assertion failed, see the error above");
            abort_run();
        end
    end

    initial begin
        seed         = 32'h97a0f100;
        clk          = 1'b0;
        reset        = 1'b1;
        address      = '0;
        din          = '0;
        uds          = 1'b0;
        lds          = 1'b0;
        write_strobe = 1'b0;
        cs           = 1'b0;
        intack       = 1'b0;
        ack          = 1'b0;
        dtc          = 1'b0;
        done_in      = 1'b0;
        vsync        = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        test_registers();
        test_timer_interrupt();
        test_xfer_stream();
        test_dma_stream();
        test_release_pacing();
        @(posedge clk);
        if (uut.u_props.fail_count == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Bound assertions failed %0d times", uut.u_props.fail_count);
            abort_run();
        end
    end

endmodule

// File: vmpeg_dvc_properties.sv
module vmpeg_dvc_properties (
    input logic clk,
    input logic reset,
    input logic bus_ack,
    input logic req,
    input logic rdy,
    input logic intreq,
    input logic pop,
    input logic valid
);

    int unsigned fail_count = 0;

    // Acknowledge toggles, so it never stays high
    bus_ack_toggles: assert property (@(posedge clk) disable iff (reset) bus_ack |=> !bus_ack)
        else begin
            $error("bus_ack high in two consecutive cycles");
            fail_count++;
        end

    req_matches_rdy: assert property (@(posedge clk) disable iff (reset) req == rdy)
        else begin
            $error("req and rdy differ");
            fail_count++;
        end

    // Event pop only from a valid FIFO head
    pop_needs_valid: assert property (@(posedge clk) disable iff (reset) pop |-> valid)
        else begin
            $error("frame event popped while valid is low");
            fail_count++;
        end

    reset_clears_outputs: assert property (@(posedge clk) reset |=> !bus_ack && !req && !intreq)
        else begin
            $error("bus_ack, req or intreq high after reset");
            fail_count++;
        end

endmodule

bind vmpeg_dvc vmpeg_dvc_properties u_props (
    .clk, .reset, .bus_ack, .req, .rdy, .intreq,
    .pop   (fe.pop),
    .valid (fe.valid)
);

// File: vmpeg_dvc.sv
module vmpeg_dvc #(
    parameter int DCLK_DIVIDER = 667,
    parameter int FIFO_DEPTH   = 64
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [23:1]                 address,
    input  logic [vmpeg_pkg::WORD_W-1:0] din,
    output logic [vmpeg_pkg::WORD_W-1:0] dout,
    input  logic                        uds,
    input  logic                        lds,
    input  logic                        write_strobe,
    input  logic                        cs,
    output logic                        bus_ack,
    output logic                        intreq,
    input  logic                        intack,
    output logic                        req,
    input  logic                        ack,
    output logic                        rdy,
    input  logic                        dtc,
    input  logic                        done_in,
    input  logic                        vsync
);
    import vmpeg_pkg::*;

    logic [7:0]            stream_byte;
    logic                  byte_valid;
    logic                  push;
    logic [WORD_W-1:0]     ev_tmpref;
    logic [TIMECODE_W-1:0] ev_timecode;
    logic                  ev_seq;
    logic                  ev_gop;
    logic                  ev_pic;
    logic                  dma_active;
    logic [WORD_W-1:0]     tcnt;
    logic                  timer_reload;
    logic                  tim_pulse;

    reg_access_if  ra ();
    frame_event_if fe ();

    // All DMA goes to video
    assign req = dma_active;
    assign rdy = dma_active;

    dvc_bus_port u_bus_port (
        .clk, .reset, .address, .din, .uds, .lds, .write_strobe, .cs,
        .ack, .dtc, .dma_active, .bus_ack, .stream_byte, .byte_valid,
        .ra (ra.bus)
    );

    mpeg_header_parser u_parser (
        .clk, .reset, .stream_byte, .byte_valid, .push,
        .ev_tmpref, .ev_timecode, .ev_seq, .ev_gop, .ev_pic
    );

    frame_event_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clk, .reset, .push,
        .tmpref_in   (ev_tmpref),
        .timecode_in (ev_timecode),
        .seq_in      (ev_seq),
        .gop_in      (ev_gop),
        .pic_in      (ev_pic),
        .ev          (fe.fifo)
    );

    dvc_system_timer #(.DCLK_DIVIDER(DCLK_DIVIDER)) u_timer (
        .clk, .reset, .tcnt,
        .reload    (timer_reload),
        .tim_pulse
    );

    dvc_registers u_registers (
        .clk, .reset, .vsync, .intack, .done_in, .ack, .tim_pulse,
        .dout, .intreq, .dma_active, .tcnt, .timer_reload,
        .ra (ra.regs),
        .ev (fe.sink)
    );

endmodule

// File: dvc_registers.sv
module dvc_registers (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        vsync,
    input  logic                        intack,
    input  logic                        done_in,
    input  logic                        ack,
    input  logic                        tim_pulse,
    output logic [vmpeg_pkg::WORD_W-1:0] dout,
    output logic                        intreq,
    output logic                        dma_active,
    output logic [vmpeg_pkg::WORD_W-1:0] tcnt,
    output logic                        timer_reload,
    reg_access_if.regs                  ra,
    frame_event_if.sink                 ev
);
    import vmpeg_pkg::*;

    logic [WORD_W-1:0]     ier;
    logic [WORD_W-1:0]     isr;
    logic [WORD_W-1:0]     isr_set;
    logic [WORD_W-1:0]     ivec;
    logic [TIMECODE_W-1:0] timecode;
    logic [WORD_W-1:0]     tmpref;
    logic                  isr_clear;
    logic                  vsync_q;
    logic                  vsync_phase;
    logic                  vsync_rise;
    logic                  release_ev;

    assign ra.rdata = (ra.word_addr == REG_TIMECODE_HI) ? timecode[31:16] :
                      (ra.word_addr == REG_TIMECODE_LO) ? timecode[15:0]  :
                      (ra.word_addr == REG_TMPREF)      ? tmpref          :
                      (ra.word_addr == REG_IER)         ? ier             :
                      (ra.word_addr == REG_ISR)         ? isr             :
                      (ra.word_addr == REG_TCNT)        ? tcnt            :
                      (ra.word_addr == REG_IVEC)        ? ivec            : '0;

    // Vector cycle returns IVEC[10:3] in both bytes
    assign dout = intack ? {ivec[10:3], ivec[10:3]} : ra.rdata;

    assign intreq       = |(isr & ier);
    assign timer_reload = ra.wr_strobe && (ra.word_addr == REG_TRLD);
    assign isr_clear    = ra.rd_strobe && (ra.word_addr == REG_ISR);

    // Release on every second rising vsync edge
    assign vsync_rise = vsync && !vsync_q;
    assign release_ev = vsync_rise && vsync_phase && ev.valid;
    assign ev.pop     = release_ev;

    always_comb begin
        isr_set          = '0;
        isr_set[ISR_TIM] = tim_pulse;
        if (release_ev) begin
            isr_set[ISR_SEQ] = ev.seq;
            isr_set[ISR_GOP] = ev.gop;
            isr_set[ISR_PIC] = ev.pic;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ier         <= '0;
            isr         <= '0;
            ivec        <= '0;
            tcnt        <= TCNT_RESET;
            dma_active  <= 1'b0;
            vsync_q     <= 1'b0;
            vsync_phase <= 1'b0;
        end else begin
            vsync_q <= vsync;
            if (vsync_rise) begin
                vsync_phase <= !vsync_phase;
            end
            // New flags survive a clearing read in the same cycle
            isr <= (isr_clear ? '0 : isr) | isr_set;
            if (done_in && ack) begin
                dma_active <= 1'b0;
            end
            if (ra.wr_strobe) begin
                case (ra.word_addr)
                    REG_IER:  ier  <= ra.wdata;
                    REG_TCNT: tcnt <= ra.wdata;
                    REG_IVEC: ivec <= ra.wdata;
                    REG_SYSCMD: begin
                        if (ra.wdata == SYSCMD_DMA_START) begin
                            dma_active <= 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (release_ev) begin
            timecode <= ev.timecode;
            tmpref   <= ev.tmpref;
        end
    end

endmodule

// File: dvc_system_timer.sv
module dvc_system_timer #(
    parameter int DCLK_DIVIDER = 667
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [vmpeg_pkg::WORD_W-1:0] tcnt,
    input  logic                        reload,
    output logic                        tim_pulse
);
    import vmpeg_pkg::*;

    localparam int DIV_W = (DCLK_DIVIDER > 1) ? $clog2(DCLK_DIVIDER) : 1;
    localparam int CNT_W = WORD_W + TIMER_FRAC;

    logic [DIV_W-1:0] div_cnt;
    logic [CNT_W-1:0] tick_cnt;
    logic             tick;

    assign tick = (div_cnt == DIV_W'(DCLK_DIVIDER - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt   <= '0;
            tick_cnt  <= '0;
            tim_pulse <= 1'b0;
        end else begin
            tim_pulse <= 1'b0;
            div_cnt   <= tick ? '0 : div_cnt + 1'b1;
            if (reload) begin
                tick_cnt <= '0;
            end else if (tick) begin
                // Upper part matches TCNT, so the period is 8*TCNT+1 ticks
                if (tick_cnt[CNT_W-1:TIMER_FRAC] == tcnt) begin
                    tim_pulse <= 1'b1;
                    tick_cnt  <= '0;
                end else begin
                    tick_cnt <= tick_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: frame_event_fifo.sv
module frame_event_fifo #(
    parameter int FIFO_DEPTH = 64
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            push,
    input  logic [vmpeg_pkg::WORD_W-1:0]     tmpref_in,
    input  logic [vmpeg_pkg::TIMECODE_W-1:0] timecode_in,
    input  logic                            seq_in,
    input  logic                            gop_in,
    input  logic                            pic_in,
    frame_event_if.fifo                     ev
);
    import vmpeg_pkg::*;

    localparam int AW      = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int ENTRY_W = WORD_W + TIMECODE_W + 3;

    logic [ENTRY_W-1:0] mem [FIFO_DEPTH];
    logic [ENTRY_W-1:0] out_q;
    logic [AW-1:0]      wr_idx;
    logic [AW-1:0]      rd_idx_q;
    logic [AW-1:0]      rd_idx_d;
    logic [AW:0]        count;
    logic               wr_ok;
    // Head entry written in the same cycle it was read out
    logic               same_d;
    logic               same_q;

    function automatic logic [AW-1:0] next_idx(input logic [AW-1:0] idx);
        next_idx = (idx == AW'(FIFO_DEPTH - 1)) ? '0 : idx + 1'b1;
    endfunction

    // Full FIFO drops the push
    assign wr_ok    = push && (count != (AW + 1)'(FIFO_DEPTH));
    assign rd_idx_d = ev.pop ? next_idx(rd_idx_q) : rd_idx_q;
    assign same_d   = wr_ok && (wr_idx == rd_idx_d);

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_idx   <= '0;
            rd_idx_q <= '0;
            count    <= '0;
            same_q   <= 1'b0;
        end else begin
            if (wr_ok) begin
                wr_idx <= next_idx(wr_idx);
            end
            if (wr_ok && !ev.pop) begin
                count <= count + 1'b1;
            end else if (ev.pop && !wr_ok && count != '0) begin
                count <= count - 1'b1;
            end
            rd_idx_q <= rd_idx_d;
            same_q   <= same_d;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_idx] <= {tmpref_in, timecode_in, seq_in, gop_in, pic_in};
        end
        out_q <= mem[rd_idx_d];
    end

    assign {ev.tmpref, ev.timecode, ev.seq, ev.gop, ev.pic} = out_q;
    assign ev.valid = (count != '0) && !same_q;

endmodule

// File: mpeg_header_parser.sv
module mpeg_header_parser (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [7:0]                      stream_byte,
    input  logic                            byte_valid,
    output logic                            push,
    output logic [vmpeg_pkg::WORD_W-1:0]     ev_tmpref,
    output logic [vmpeg_pkg::TIMECODE_W-1:0] ev_timecode,
    output logic                            ev_seq,
    output logic                            ev_gop,
    output logic                            ev_pic
);
    import vmpeg_pkg::*;

    typedef enum logic [3:0] {
        IDLE,
        ZERO1,
        ZERO2,
        MATCH,
        SEQ_HDR,
        SLICE,
        GOP0,
        GOP1,
        GOP2,
        GOP3,
        PIC0,
        PIC1,
        PIC2,
        PIC3
    } parse_state_t;

    parse_state_t     state;
    logic [TSN_W-1:0] tsn;
    logic [TSN_W-1:0] next_tsn;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= IDLE;
            push        <= 1'b0;
            ev_seq      <= 1'b0;
            ev_gop      <= 1'b0;
            ev_pic      <= 1'b0;
            ev_tmpref   <= '0;
            ev_timecode <= '0;
            next_tsn    <= '0;
        end else begin
            push <= 1'b0;
            // Flags start fresh for the next frame, fields hold
            if (push) begin
                ev_seq <= 1'b0;
                ev_gop <= 1'b0;
                ev_pic <= 1'b0;
            end
            if (byte_valid) begin
                case (state)
                    IDLE:  state <= (stream_byte == 8'h00) ? ZERO1 : IDLE;
                    ZERO1: state <= (stream_byte == 8'h00) ? ZERO2 : IDLE;
                    ZERO2: begin
                        // Extra zero bytes are legal stuffing
                        if (stream_byte == 8'h00) begin
                            state <= ZERO2;
                        end else if (stream_byte == SC_PREFIX_LAST) begin
                            state <= MATCH;
                        end else begin
                            state <= IDLE;
                        end
                    end
                    MATCH: begin
                        case (stream_byte)
                            SC_SEQ:   state <= SEQ_HDR;
                            SC_GOP:   state <= GOP0;
                            SC_PIC:   state <= PIC0;
                            SC_SLICE: state <= SLICE;
                            default:  state <= IDLE;
                        endcase
                    end
                    SEQ_HDR: begin
                        ev_seq <= 1'b1;
                        state  <= IDLE;
                    end
                    GOP0: state <= GOP1;
                    GOP1: begin
                        ev_timecode[27:25] <= stream_byte[2:0];
                        state              <= GOP2;
                    end
                    GOP2: begin
                        ev_timecode[24:22] <= stream_byte[7:5];
                        ev_timecode[21:17] <= stream_byte[4:0];
                        state              <= GOP3;
                    end
                    GOP3: begin
                        ev_timecode[16] <= stream_byte[7];
                        ev_gop          <= 1'b1;
                        // New group restarts the temporal numbering
                        next_tsn        <= '0;
                        state           <= IDLE;
                    end
                    PIC0: begin
                        tsn[9:2] <= stream_byte;
                        state    <= PIC1;
                    end
                    PIC1: begin
                        tsn[1:0] <= stream_byte[7:6];
                        state    <= PIC2;
                    end
                    PIC2: begin
                        // Only in-order pictures update TMPREF
                        if (tsn == next_tsn) begin
                            ev_tmpref[11:2] <= tsn;
                            next_tsn        <= next_tsn + 1'b1;
                        end
                        state <= PIC3;
                    end
                    PIC3: begin
                        ev_pic <= 1'b1;
                        push   <= 1'b1;
                        state  <= IDLE;
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

endmodule

// File: dvc_bus_port.sv
module dvc_bus_port (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [23:1]                 address,
    input  logic [vmpeg_pkg::WORD_W-1:0] din,
    input  logic                        uds,
    input  logic                        lds,
    input  logic                        write_strobe,
    input  logic                        cs,
    input  logic                        ack,
    input  logic                        dtc,
    input  logic                        dma_active,
    output logic                        bus_ack,
    output logic [7:0]                  stream_byte,
    output logic                        byte_valid,
    reg_access_if.bus                   ra
);
    import vmpeg_pkg::*;

    logic       access;
    logic       xfer_write;
    logic       word_valid;
    logic       word_valid_q;
    logic [7:0] low_byte_q;

    assign access = cs && (uds || lds);

    // Strobes land in the second cycle of an access, when bus_ack is high
    assign ra.word_addr = address[15:1];
    assign ra.wdata     = din;
    assign ra.wr_strobe = access && bus_ack && write_strobe;
    assign ra.rd_strobe = access && bus_ack && !write_strobe;

    always_ff @(posedge clk) begin
        if (reset) begin
            bus_ack <= 1'b0;
        end else if (access) begin
            bus_ack <= !bus_ack;
        end else begin
            bus_ack <= 1'b0;
        end
    end

    // A stream word comes from an XFER write or a DMA beat
    assign xfer_write = ra.wr_strobe && (ra.word_addr == REG_XFER);
    assign word_valid = xfer_write || (ack && dtc && dma_active);

    always_ff @(posedge clk) begin
        if (reset) begin
            word_valid_q <= 1'b0;
        end else begin
            word_valid_q <= word_valid;
        end
    end

    // Low byte waits one cycle behind the high byte
    always_ff @(posedge clk) begin
        if (word_valid) begin
            low_byte_q <= din[7:0];
        end
    end

    assign stream_byte = word_valid_q ? low_byte_q : din[15:8];
    assign byte_valid  = word_valid_q || word_valid;

endmodule

// File: dvc_interfaces.sv
// Register traffic from the bus port to the register file
interface reg_access_if;
    import vmpeg_pkg::*;

    logic [REG_ADDR_W-1:0] word_addr;
    logic [WORD_W-1:0]     wdata;
    logic                  wr_strobe;
    logic                  rd_strobe;
    logic [WORD_W-1:0]     rdata;

    modport bus (
        output word_addr, wdata, wr_strobe, rd_strobe,
        input  rdata
    );

    modport regs (
        input  word_addr, wdata, wr_strobe, rd_strobe,
        output rdata
    );
endinterface

// Frame events from the FIFO head to the register file
interface frame_event_if;
    import vmpeg_pkg::*;

    logic [WORD_W-1:0]     tmpref;
    logic [TIMECODE_W-1:0] timecode;
    logic                  seq;
    logic                  gop;
    logic                  pic;
    logic                  valid;
    // One-cycle pulse, only while valid
    logic                  pop;

    modport fifo (
        output tmpref, timecode, seq, gop, pic, valid,
        input  pop
    );

    modport sink (
        input  tmpref, timecode, seq, gop, pic, valid,
        output pop
    );
endinterface

// File: vmpeg_pkg.sv
package vmpeg_pkg;

    // Data and field widths
    localparam int WORD_W     = 16;
    localparam int REG_ADDR_W = 15;
    localparam int TSN_W      = 10;
    localparam int TIMECODE_W = 32;
    // Counter bits below the TCNT compare
    localparam int TIMER_FRAC = 3;

    // Register word addresses, address bits 15:1
    localparam logic [REG_ADDR_W-1:0] REG_TIMECODE_HI = 15'h202C;
    localparam logic [REG_ADDR_W-1:0] REG_TIMECODE_LO = 15'h202D;
    localparam logic [REG_ADDR_W-1:0] REG_TMPREF      = 15'h202E;
    localparam logic [REG_ADDR_W-1:0] REG_IER         = 15'h2030;
    localparam logic [REG_ADDR_W-1:0] REG_ISR         = 15'h2031;
    localparam logic [REG_ADDR_W-1:0] REG_TCNT        = 15'h2032;
    localparam logic [REG_ADDR_W-1:0] REG_TRLD        = 15'h2057;
    localparam logic [REG_ADDR_W-1:0] REG_SYSCMD      = 15'h2060;
    localparam logic [REG_ADDR_W-1:0] REG_IVEC        = 15'h206E;
    localparam logic [REG_ADDR_W-1:0] REG_XFER        = 15'h206F;

    localparam logic [WORD_W-1:0] SYSCMD_DMA_START = 16'h8000;
    localparam logic [WORD_W-1:0] TCNT_RESET       = 16'd55;

    // Start codes, following the 00 00 01 prefix
    localparam logic [7:0] SC_PREFIX_LAST = 8'h01;
    localparam logic [7:0] SC_SEQ         = 8'hB3;
    localparam logic [7:0] SC_GOP         = 8'hB8;
    localparam logic [7:0] SC_PIC         = 8'h00;
    localparam logic [7:0] SC_SLICE       = 8'h01;

    // Interrupt status bit positions
    localparam logic [3:0] ISR_SEQ = 4'd0;
    localparam logic [3:0] ISR_GOP = 4'd1;
    localparam logic [3:0] ISR_PIC = 4'd2;
    localparam logic [3:0] ISR_TIM = 4'd8;

endpackage
